//--- logic/up_sys_pkg.sv
package up_sys_pkg;

	// ==============================
	// Datapath and memory geometry
	// ==============================
	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;
	localparam int MEM_DEPTH = 256; // One byte per address.

	// ==============================
	// UART timing
	// ==============================
	localparam int CLKS_PER_BIT_DEF = 16; // Overridden from the top level.

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

//--- logic/up_isa_pkg.sv
package up_isa_pkg;

	// Opcode lives in the high nibble of the first instruction byte.
	typedef enum logic [3:0] {
		HLT = 4'h0,
		LDI = 4'h1,
		LDA = 4'h2,
		STA = 4'h3,
		ADD = 4'h4,
		SUB = 4'h5,
		AND = 4'h6,
		OR  = 4'h7,
		XOR = 4'h8,
		JMP = 4'h9,
		JZ  = 4'hA,
		JNZ = 4'hB
	} opcode_t;

	localparam int OPC_HI = 7; // Low nibble of the opcode byte is ignored.
	localparam int OPC_LO = 4;

	// ==============================
	// Boot program
	// ==============================
	localparam int BOOT_LEN = 8;
	localparam up_sys_pkg::byte_t BOOT_VALUE = 8'h5A;
	localparam up_sys_pkg::addr_t BOOT_STORE_ADDR = 8'd80;

	localparam up_sys_pkg::byte_t BOOT_IMAGE [BOOT_LEN] = '{
		{LDI, 4'h0}, BOOT_VALUE,
		{STA, 4'h0}, BOOT_STORE_ADDR,
		{HLT, 4'h0}, 8'h00,
		8'h00, 8'h00
	};

endpackage

//--- logic/up_mem_if.sv
interface up_mem_if;

	up_sys_pkg::addr_t addr;
	up_sys_pkg::byte_t wdata;
	logic we; // Single-cycle store strobe.
	up_sys_pkg::byte_t rdata;
	logic re; // High when a store may be issued.

	modport core (
		output addr, wdata, we,
		input rdata, re
	);

	modport mem (
		input addr, wdata, we,
		output rdata, re
	);

endinterface

//--- logic/up_memory.sv
module up_memory (
	input logic clk,
	input logic nRst,

	up_mem_if.mem mem,

	input logic host_we,
	input up_sys_pkg::addr_t host_addr,
	input up_sys_pkg::byte_t host_wdata,
	output up_sys_pkg::byte_t host_rdata,

	input logic busy_tx,
	output up_sys_pkg::byte_t data_tx,
	output logic transmit
);
	import up_sys_pkg::*;
	import up_isa_pkg::*;

	byte_t mem_array [MEM_DEPTH];

	// ==============================
	// Read ports
	// ==============================
	assign mem.rdata = mem_array[mem.addr];
	assign host_rdata = mem_array[host_addr];

	// A pending or active frame holds off the next store.
	assign mem.re = ~(busy_tx | transmit);

	// ==============================
	// Array and transmit request
	// ==============================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem_array[i] <= '0;
			end
			for (int j = 0; j < BOOT_LEN; j++) begin
				mem_array[j] <= BOOT_IMAGE[j]; // Boot bytes win over the clear.
			end
			transmit <= 1'b0;
		end else begin
			if (busy_tx) begin
				transmit <= 1'b0; // The UART has taken the byte.
			end
			if (mem.we) begin
				mem_array[mem.addr] <= mem.wdata;
				transmit <= 1'b1;
			end else if (host_we) begin
				mem_array[host_addr] <= host_wdata; // Host writes only while halted.
			end
		end
	end

	// Only core stores are mirrored to the UART.
	always_ff @(posedge clk) begin
		if (mem.we) begin
			data_tx <= mem.wdata;
		end
	end

endmodule

//--- logic/up_core.sv
module up_core (
	input logic clk,
	input logic nRst,

	input logic start,
	output logic halted,

	up_mem_if.core mem
);
	import up_sys_pkg::*;
	import up_isa_pkg::*;

	typedef enum logic [1:0] {
		S_HALT,
		S_FETCH_OP,
		S_FETCH_ARG,
		S_EXEC
	} state_t;

	state_t state;
	addr_t pc;
	byte_t acc;
	logic zero;
	opcode_t opcode;
	byte_t operand;

	byte_t alu_res;
	logic acc_load;
	logic store_go;

	assign halted = (state == S_HALT);

	// ==============================
	// Memory bus
	// ==============================
	// Fetches read at pc, execute reads the operand address.
	assign mem.addr = (state == S_EXEC) ? operand : pc;
	assign mem.wdata = acc;

	// A store fires only in a cycle where the memory allows it.
	assign store_go = (state == S_EXEC) && (opcode == STA) && mem.re;
	assign mem.we = store_go;

	// ==============================
	// Accumulator update
	// ==============================
	always_comb begin
		alu_res = acc;
		acc_load = 1'b1;
		case (opcode)
			LDI: alu_res = operand;
			LDA: alu_res = mem.rdata;
			ADD: alu_res = acc + mem.rdata;
			SUB: alu_res = acc - mem.rdata;
			AND: alu_res = acc & mem.rdata;
			OR: alu_res = acc | mem.rdata;
			XOR: alu_res = acc ^ mem.rdata;
			default: acc_load = 1'b0; // Stores, jumps and halts leave acc alone.
		endcase
	end

	// ==============================
	// Fetch / execute FSM
	// ==============================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= S_FETCH_OP; // Boot image runs straight out of reset.
			pc <= '0;
			acc <= '0;
			zero <= 1'b1;
			opcode <= HLT;
			operand <= '0;
		end else begin
			case (state)
				S_HALT: begin
					if (start) begin
						state <= S_FETCH_OP;
						pc <= '0;
						acc <= '0;
						zero <= 1'b1;
					end
				end

				S_FETCH_OP: begin
					opcode <= opcode_t'(mem.rdata[OPC_HI:OPC_LO]);
					pc <= pc + addr_t'(1);
					state <= S_FETCH_ARG;
				end

				S_FETCH_ARG: begin
					operand <= mem.rdata;
					pc <= pc + addr_t'(1);
					state <= S_EXEC;
				end

				S_EXEC: begin
					if (acc_load) begin
						acc <= alu_res;
						zero <= (alu_res == '0);
					end
					state <= S_FETCH_OP;
					case (opcode)
						LDI, LDA, ADD, SUB, AND, OR, XOR: begin
						end
						STA: begin
							if (!store_go) begin
								state <= S_EXEC; // Wait here until re is high.
							end
						end
						JMP: pc <= operand;
						JZ: begin
							if (zero) begin
								pc <= operand;
							end
						end
						JNZ: begin
							if (!zero) begin
								pc <= operand;
							end
						end
						default: state <= S_HALT; // HLT and codes C to F.
					endcase
				end

				default: state <= S_HALT;
			endcase
		end
	end

endmodule

//--- logic/uart_tx.sv
module uart_tx #(
	parameter int CLKS_PER_BIT = up_sys_pkg::CLKS_PER_BIT_DEF
) (
	input logic clk,
	input logic nRst,
	input logic transmit,
	input up_sys_pkg::byte_t data_tx,
	output logic busy_tx,
	output logic tx
);
	import up_sys_pkg::*;

	localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	typedef enum logic [1:0] {
		T_IDLE,
		T_START,
		T_DATA,
		T_STOP
	} tx_state_t;

	tx_state_t state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	byte_t shift_reg;
	logic bit_done;

	assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	// ==============================
	// Frame sequencer
	// ==============================
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= T_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			busy_tx <= 1'b0;
			tx <= 1'b1; // Line idles high.
		end else begin
			clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
			case (state)
				T_IDLE: begin
					clk_cnt <= '0;
					if (transmit) begin
						state <= T_START;
						busy_tx <= 1'b1;
						tx <= 1'b0;
					end
				end
				T_START: begin
					if (bit_done) begin
						state <= T_DATA;
						bit_idx <= '0;
						tx <= shift_reg[0];
					end
				end
				T_DATA: begin
					if (bit_done) begin
						bit_idx <= bit_idx + 1'b1;
						tx <= shift_reg[1];
						if (bit_idx == 3'd7) begin
							state <= T_STOP;
							tx <= 1'b1;
						end
					end
				end
				default: begin
					if (bit_done) begin
						state <= T_IDLE;
						busy_tx <= 1'b0; // Stop bit fully sent.
					end
				end
			endcase
		end
	end

	// LSB goes out first, so the byte shifts right after each data bit.
	always_ff @(posedge clk) begin
		if (state == T_IDLE && transmit) begin
			shift_reg <= data_tx;
		end else if (state == T_DATA && bit_done) begin
			shift_reg <= shift_reg >> 1;
		end
	end

endmodule

//--- logic/up_top.sv
module up_top #(
	parameter int CLKS_PER_BIT = up_sys_pkg::CLKS_PER_BIT_DEF
) (
	input logic clk,
	input logic nRst,

	input logic start,
	output logic halted,

	input logic host_we,
	input up_sys_pkg::addr_t host_addr,
	input up_sys_pkg::byte_t host_wdata,
	output up_sys_pkg::byte_t host_rdata,

	output logic tx
);
	import up_sys_pkg::*;

	// ==============================
	// Memory to UART link
	// ==============================
	byte_t data_tx;
	logic transmit;
	logic busy_tx;

	up_mem_if i_mem_if ();

	up_core i_core (
		.clk(clk),
		.nRst(nRst),
		.start(start),
		.halted(halted),
		.mem(i_mem_if.core)
	);

	up_memory i_memory (
		.clk(clk),
		.nRst(nRst),
		.mem(i_mem_if.mem),
		.host_we(host_we),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_rdata(host_rdata),
		.busy_tx(busy_tx),
		.data_tx(data_tx),
		.transmit(transmit)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) i_uart_tx (
		.clk(clk),
		.nRst(nRst),
		.transmit(transmit),
		.data_tx(data_tx),
		.busy_tx(busy_tx),
		.tx(tx)
	);

endmodule

//--- sim/up_checker.sv
module up_checker #(
	parameter int CLKS_PER_BIT = 4
) (
	input logic clk,
	input logic nRst,
	input logic tx,
	input logic halted,
	input logic start,
	input up_sys_pkg::addr_t host_addr,
	input up_sys_pkg::byte_t host_rdata,
	input logic exp_valid,
	input up_sys_pkg::byte_t exp_byte,
	input logic rd_check,
	input up_sys_pkg::byte_t rd_exp,
	output int frames,
	output int tx_errors,
	output int rd_errors,
	output int frame_errors,
	output int halt_errors
);
	import up_sys_pkg::*;

	localparam int EXP_DEPTH = 1024;

	byte_t exp_mem [EXP_DEPTH]; // Expected UART bytes in store order.
	int wr_ptr = 0;
	int rd_ptr = 0;
	int frame_cnt = 0;
	int tx_err_cnt = 0;
	int rd_err_cnt = 0;
	int framing_cnt = 0;
	int halt_err_cnt = 0;
	logic start_taken = 1'b0;

	assign frames = frame_cnt;
	assign tx_errors = tx_err_cnt;
	assign rd_errors = rd_err_cnt;
	assign frame_errors = framing_cnt;
	assign halt_errors = halt_err_cnt;

	always @(posedge clk) begin
		if (exp_valid) begin
			exp_mem[wr_ptr % EXP_DEPTH] <= exp_byte;
			wr_ptr <= wr_ptr + 1;
		end
	end

	// ==============================
	// Serial line decoder
	// ==============================
	task automatic receive_frame();
		byte_t data;
		byte_t expected;
		repeat (CLKS_PER_BIT / 2) @(posedge clk); // Move to the middle of the start bit.
		if (tx !== 1'b0) begin
			framing_cnt++;
			$display("Start bit on tx at %0t did not last until mid-bit", $time);
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(posedge clk);
			data[i] = tx; // LSB arrives first.
		end
		repeat (CLKS_PER_BIT) @(posedge clk);
		if (tx !== 1'b1) begin
			framing_cnt++;
			$display("** Error at %0t: tx stop bit = %b, expected 1", $time, tx);
		end
		frame_cnt++;
		if (rd_ptr == wr_ptr) begin
			tx_err_cnt++;
			$display("Frame carrying %02h at %0t was sent with no store expected", data, $time);
		end else begin
			expected = exp_mem[rd_ptr % EXP_DEPTH];
			rd_ptr++;
			if (data !== expected) begin
				tx_err_cnt++;
				$display("** Error at %0t: tx = %02h, expected %02h", $time, data, expected);
			end
		end
	endtask

	initial begin : serial_rx
		forever begin
			@(posedge clk);
			if (nRst && tx === 1'b0) begin
				receive_frame();
			end
		end
	end

	// ==============================
	// Start acceptance
	// ==============================
	// A start seen while halted must drop halted one cycle later.
	always @(posedge clk) begin
		start_taken <= nRst && start && halted;
		if (start_taken && halted) begin
			halt_err_cnt <= halt_err_cnt + 1;
			$display("** Error at %0t: halted = %b, expected 0", $time, halted);
		end
	end

	// ==============================
	// Host read port
	// ==============================
	always @(posedge clk) begin
		if (rd_check) begin
			if (!halted) begin
				rd_err_cnt <= rd_err_cnt + 1;
				$display("Host read of address %02h at %0t happened while the core ran",
					host_addr, $time);
			end else if (host_rdata !== rd_exp) begin
				rd_err_cnt <= rd_err_cnt + 1;
				$display("** Error at %0t: host_rdata[%02h] = %02h, expected %02h",
					$time, host_addr, host_rdata, rd_exp);
			end
		end
	end

endmodule

//--- sim/tb_up.sv
module tb_up;
	import up_sys_pkg::*;
	import up_isa_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int CLKS = 4;
	localparam int NUM_PROGS = 12;
	localparam int MAX_INSTR = 32;
	localparam int LOAD_CYCLES = 128 + 64 + MAX_INSTR + 4;
	localparam int PROG_CYCLES = MAX_INSTR * 3 + MAX_INSTR * (10 * CLKS + 4) + LOAD_CYCLES;
	localparam int WATCHDOG_CYCLES = (NUM_PROGS + 1) * PROG_CYCLES + 1000;

	logic clk = 1'b0;
	logic nRst;
	logic start;
	logic halted;
	logic host_we;
	addr_t host_addr;
	byte_t host_wdata;
	byte_t host_rdata;
	logic tx;
	logic exp_valid;
	byte_t exp_byte;
	logic rd_check;
	byte_t rd_exp;
	int frames;
	int tx_errors;
	int rd_errors;
	int frame_errors;
	int halt_errors;

	logic [31:0] lfsr = 32'hbe455eda;
	byte_t model_mem [MEM_DEPTH]; // Memory image as the ISA model sees it.
	byte_t exp_tx_q [$];
	int sent_total = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	up_top #(.CLKS_PER_BIT(CLKS)) i_dut (
		.clk(clk), .nRst(nRst), .start(start), .halted(halted),
		.host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
		.host_rdata(host_rdata), .tx(tx)
	);

	up_checker #(.CLKS_PER_BIT(CLKS)) i_check (
		.clk(clk), .nRst(nRst), .tx(tx), .halted(halted), .start(start),
		.host_addr(host_addr), .host_rdata(host_rdata),
		.exp_valid(exp_valid), .exp_byte(exp_byte), .rd_check(rd_check), .rd_exp(rd_exp),
		.frames(frames), .tx_errors(tx_errors), .rd_errors(rd_errors),
		.frame_errors(frame_errors), .halt_errors(halt_errors)
	);

	// ==============================
	// Random source
	// ==============================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	function automatic byte_t take_bits(input int n);
		byte_t v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [3:0] choose_opcode(input byte_t sel);
		case (sel[3:0])
			4'd0, 4'd1: return LDI;
			4'd2, 4'd3: return LDA;
			4'd4, 4'd5, 4'd6: return STA; // Runs of stores hit the UART back to back.
			4'd7: return ADD;
			4'd8: return SUB;
			4'd9: return AND;
			4'd10: return OR;
			4'd11: return XOR;
			4'd12, 4'd13: return JZ;
			4'd14: return JNZ;
			default: return JMP;
		endcase
	endfunction

	// ==============================
	// ISA model
	// ==============================
	function automatic void run_model();
		addr_t pc;
		byte_t acc;
		byte_t arg;
		logic zero;
		logic [3:0] op;
		pc = '0;
		acc = '0;
		zero = 1'b1;
		for (int step = 0; step < 256; step++) begin
			op = model_mem[pc][7:4];
			arg = model_mem[pc + addr_t'(1)];
			pc = pc + addr_t'(2);
			case (op)
				LDI: acc = arg;
				LDA: acc = model_mem[arg];
				ADD: acc = acc + model_mem[arg];
				SUB: acc = acc - model_mem[arg];
				AND: acc = acc & model_mem[arg];
				OR: acc = acc | model_mem[arg];
				XOR: acc = acc ^ model_mem[arg];
				STA: begin
					model_mem[arg] = acc;
					exp_tx_q.push_back(acc);
				end
				JMP: pc = arg;
				JZ: pc = zero ? arg : pc;
				JNZ: pc = zero ? pc : arg;
				default: return; // HLT and codes C to F.
			endcase
			if (op inside {LDI, LDA, ADD, SUB, AND, OR, XOR}) begin
				zero = (acc == 8'h00);
			end
		end
	endfunction

	// ==============================
	// Host port and stimulus
	// ==============================
	task automatic load_byte(input addr_t a, input byte_t d);
		@(posedge clk);
		host_we <= 1'b1;
		host_addr <= a;
		host_wdata <= d;
		rd_check <= 1'b0;
		model_mem[a] = d;
	endtask

	task automatic check_read(input addr_t a);
		@(posedge clk);
		host_we <= 1'b0;
		host_addr <= a;
		rd_check <= 1'b1;
		rd_exp <= model_mem[a];
	endtask

	task automatic make_program();
		logic [3:0] opc;
		byte_t arg;
		byte_t r;
		for (int a = 128; a < 192; a++) begin
			load_byte(addr_t'(a), take_bits(8));
		end
		for (int pc = 0; pc < 62; pc += 2) begin
			opc = choose_opcode(take_bits(4));
			case (opc)
				LDI: arg = take_bits(8);
				STA: arg = 8'hC0 | take_bits(6);
				JMP, JZ, JNZ: begin
					arg = byte_t'(pc + 2) + (take_bits(3) << 1); // Forward only.
					arg = (arg > 8'd62) ? 8'd62 : arg;
				end
				default: arg = 8'h80 | take_bits(7);
			endcase
			r = take_bits(4);
			load_byte(addr_t'(pc), {opc, r[3:0]}); // Low nibble is noise.
			load_byte(addr_t'(pc + 1), arg);
		end
		r = take_bits(8);
		load_byte(8'd62, r[7] ? (r | 8'hC0) : (r & 8'h0F));
		load_byte(8'd63, take_bits(8));
		@(posedge clk);
		host_we <= 1'b0;
	endtask

	task automatic send_expected();
		while (exp_tx_q.size() > 0) begin
			@(posedge clk);
			exp_valid <= 1'b1;
			exp_byte <= exp_tx_q.pop_front();
			sent_total++;
		end
		@(posedge clk);
		exp_valid <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done();
		@(posedge clk);
		while (!halted || frames < sent_total) begin
			@(posedge clk);
		end
	endtask

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		nRst = 1'b0;
		start = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		exp_valid = 1'b0;
		exp_byte = '0;
		rd_check = 1'b0;
		rd_exp = '0;
		foreach (model_mem[a]) begin
			model_mem[a] = 8'h00;
		end
		model_mem[0] = 8'h10; // Boot program is LDI 5A, STA 80, HLT.
		model_mem[1] = 8'h5A;
		model_mem[2] = 8'h30;
		model_mem[3] = 8'd80;
		repeat (8) @(posedge clk);
		nRst <= 1'b1;
		run_model();
		send_expected();
		wait_done();
		check_read(8'd80);
		check_read(8'd0);
		for (int p = 0; p < NUM_PROGS; p++) begin
			make_program();
			run_model();
			send_expected();
			pulse_start();
			wait_done();
			for (int a = 192; a < 256; a++) begin
				check_read(addr_t'(a));
			end
		end
		@(posedge clk);
		rd_check <= 1'b0;
		repeat (20 * CLKS) @(posedge clk); // Any stray frame would surface here.
		$display("Frames %0d of %0d, errors: tx %0d, host read %0d, framing %0d, halted %0d",
			frames, sent_total, tx_errors, rd_errors, frame_errors, halt_errors);
		if (tx_errors + rd_errors + frame_errors + halt_errors == 0
			&& frames == sent_total) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- compile.f
logic/up_sys_pkg.sv
logic/up_isa_pkg.sv
logic/up_mem_if.sv
logic/up_memory.sv
logic/up_core.sv
logic/uart_tx.sv
logic/up_top.sv
sim/up_checker.sv
sim/tb_up.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and grade the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_up -f compile.f \
	&& ./obj_dir/Vtb_up > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
